// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_dhs_periph -f src.f || exit 1
out=$(./obj_dir/Vtb_dhs_periph 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Everything OK$" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: source/apb_axil_bridge.sv
module apb_axil_bridge (
  input  logic                       clk_i,
  input  logic                       arst_n_i,

  // APB subordinate side
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [dhs_pkg::ADDR_W-1:0] paddr_i,
  input  logic [dhs_pkg::DATA_W-1:0] pwdata_i,
  input  logic [dhs_pkg::STRB_W-1:0] pstrb_i,
  output logic                       pready_o,
  output logic [dhs_pkg::DATA_W-1:0] prdata_o,
  output logic                       pslverr_o,

  // AXI-Lite manager side
  output logic [dhs_pkg::ADDR_W-1:0] m_aw_addr_o,
  output logic                       m_aw_valid_o,
  input  logic                       m_aw_ready_i,
  output logic [dhs_pkg::DATA_W-1:0] m_w_data_o,
  output logic [dhs_pkg::STRB_W-1:0] m_w_strb_o,
  output logic                       m_w_valid_o,
  input  logic                       m_w_ready_i,
  input  logic [dhs_pkg::RESP_W-1:0] m_b_resp_i,
  input  logic                       m_b_valid_i,
  output logic                       m_b_ready_o,
  output logic [dhs_pkg::ADDR_W-1:0] m_ar_addr_o,
  output logic                       m_ar_valid_o,
  input  logic                       m_ar_ready_i,
  input  logic [dhs_pkg::DATA_W-1:0] m_r_data_i,
  input  logic [dhs_pkg::RESP_W-1:0] m_r_resp_i,
  input  logic                       m_r_valid_i,
  output logic                       m_r_ready_o
);

  import dhs_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WR_WAIT,
    ST_RD_WAIT,
    ST_DONE
  } state_e;

  state_e            state_q;
  logic              aw_valid_q;
  logic              w_valid_q;
  logic              ar_valid_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] strb_q;
  logic [DATA_W-1:0] rdata_q;
  logic [RESP_W-1:0] resp_q;
  logic              start;

  // Access phase seen while idle
  assign start = (state_q == ST_IDLE) & psel_i & penable_i;

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ST_IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      ar_valid_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start && pwrite_i) begin
            aw_valid_q <= 1'b1;
            w_valid_q  <= 1'b1;
            state_q    <= ST_WR_WAIT;
          end else if (start) begin
            ar_valid_q <= 1'b1;
            state_q    <= ST_RD_WAIT;
          end
        end
        ST_WR_WAIT: begin
          // AW and W may leave on different edges
          if (m_aw_ready_i) aw_valid_q <= 1'b0;
          if (m_w_ready_i) w_valid_q <= 1'b0;
          if (m_b_valid_i) state_q <= ST_DONE;
        end
        ST_RD_WAIT: begin
          if (m_ar_ready_i) ar_valid_q <= 1'b0;
          if (m_r_valid_i) state_q <= ST_DONE;
        end
        default: begin
          // Single pready cycle, then back to idle
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Request payload and returned result
  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q  <= paddr_i;
      wdata_q <= pwdata_i;
      strb_q  <= pstrb_i;
    end
    if (m_b_valid_i && m_b_ready_o) begin
      resp_q <= m_b_resp_i;
    end
    if (m_r_valid_i && m_r_ready_o) begin
      rdata_q <= m_r_data_i;
      resp_q  <= m_r_resp_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign m_aw_addr_o  = addr_q;
  assign m_aw_valid_o = aw_valid_q;
  assign m_w_data_o   = wdata_q;
  assign m_w_strb_o   = strb_q;
  assign m_w_valid_o  = w_valid_q;
  assign m_b_ready_o  = (state_q == ST_WR_WAIT);
  assign m_ar_addr_o  = addr_q;
  assign m_ar_valid_o = ar_valid_q;
  assign m_r_ready_o  = (state_q == ST_RD_WAIT);

  assign pready_o  = (state_q == ST_DONE);
  assign prdata_o  = rdata_q;
  assign pslverr_o = pready_o & (resp_q != RESP_OKAY);

endmodule

// File: source/boot_rom.sv
module boot_rom (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  output logic [dhs_pkg::RESP_W-1:0] b_resp_o,
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  input  logic [dhs_pkg::ADDR_W-1:0] ar_addr_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  output logic [dhs_pkg::DATA_W-1:0] r_data_o,
  output logic [dhs_pkg::RESP_W-1:0] r_resp_o,
  output logic                       r_valid_o,
  input  logic                       r_ready_i
);

  import dhs_pkg::*;

  logic                         wr_accept;
  logic                         rd_accept;
  logic                         b_valid_q;
  logic                         r_valid_q;
  logic [ADDR_W-1:0]            rd_off;
  logic [$clog2(ROM_WORDS)-1:0] rd_idx;
  logic [DATA_W-1:0]            r_data_q;

  // No new request while the previous response waits
  assign wr_accept = aw_valid_i & w_valid_i & ~b_valid_q;
  assign rd_accept = ar_valid_i & ~r_valid_q;

  assign rd_off = ar_addr_i - ROM_BASE;
  assign rd_idx = rd_off[2 +: $clog2(ROM_WORDS)];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_accept) b_valid_q <= 1'b1;
      else if (b_ready_i) b_valid_q <= 1'b0;
      if (rd_accept) r_valid_q <= 1'b1;
      else if (r_ready_i) r_valid_q <= 1'b0;
    end
  end

  // Pattern word with the index in the low byte
  always_ff @(posedge clk_i) begin
    if (rd_accept) r_data_q <= {ROM_PATTERN[DATA_W-1:8], 8'(rd_idx)};
  end

  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;
  assign b_resp_o   = RESP_SLVERR;
  assign b_valid_o  = b_valid_q;
  assign ar_ready_o = ~r_valid_q;
  assign r_data_o   = r_data_q;
  assign r_resp_o   = RESP_OKAY;
  assign r_valid_o  = r_valid_q;

endmodule

// File: source/dhs_periph_top.sv
module dhs_periph_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [dhs_pkg::ADDR_W-1:0] paddr_i,
  input  logic [dhs_pkg::DATA_W-1:0] pwdata_i,
  input  logic [dhs_pkg::STRB_W-1:0] pstrb_i,
  output logic                       pready_o,
  output logic                       pslverr_o,
  output logic [dhs_pkg::DATA_W-1:0] prdata_o
);

  import dhs_pkg::*;

  // Bridge to link
  logic [ADDR_W-1:0] br_aw_addr, br_ar_addr;
  logic [DATA_W-1:0] br_w_data, br_r_data;
  logic [STRB_W-1:0] br_w_strb;
  logic [RESP_W-1:0] br_b_resp, br_r_resp;
  logic              br_aw_valid, br_aw_ready, br_w_valid, br_w_ready;
  logic              br_b_valid, br_b_ready, br_ar_valid, br_ar_ready;
  logic              br_r_valid, br_r_ready;

  // Link to boot ROM
  logic [ADDR_W-1:0] rom_ar_addr;
  logic [DATA_W-1:0] rom_r_data;
  logic [RESP_W-1:0] rom_b_resp, rom_r_resp;
  logic              rom_aw_valid, rom_aw_ready, rom_w_valid, rom_w_ready;
  logic              rom_b_valid, rom_b_ready, rom_ar_valid, rom_ar_ready;
  logic              rom_r_valid, rom_r_ready;

  // Link to scratch bank
  logic [ADDR_W-1:0] scr_aw_addr, scr_ar_addr;
  logic [DATA_W-1:0] scr_w_data, scr_r_data;
  logic [STRB_W-1:0] scr_w_strb;
  logic [RESP_W-1:0] scr_b_resp, scr_r_resp;
  logic              scr_aw_valid, scr_aw_ready, scr_w_valid, scr_w_ready;
  logic              scr_b_valid, scr_b_ready, scr_ar_valid, scr_ar_ready;
  logic              scr_r_valid, scr_r_ready;

  //////////////////////////////////////////////////////////////////////
  // APB entry
  //////////////////////////////////////////////////////////////////////

  apb_axil_bridge apb_bridge_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .pstrb_i     (pstrb_i),
    .pready_o    (pready_o),
    .prdata_o    (prdata_o),
    .pslverr_o   (pslverr_o),
    .m_aw_addr_o (br_aw_addr),
    .m_aw_valid_o(br_aw_valid),
    .m_aw_ready_i(br_aw_ready),
    .m_w_data_o  (br_w_data),
    .m_w_strb_o  (br_w_strb),
    .m_w_valid_o (br_w_valid),
    .m_w_ready_i (br_w_ready),
    .m_b_resp_i  (br_b_resp),
    .m_b_valid_i (br_b_valid),
    .m_b_ready_o (br_b_ready),
    .m_ar_addr_o (br_ar_addr),
    .m_ar_valid_o(br_ar_valid),
    .m_ar_ready_i(br_ar_ready),
    .m_r_data_i  (br_r_data),
    .m_r_resp_i  (br_r_resp),
    .m_r_valid_i (br_r_valid),
    .m_r_ready_o (br_r_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Peripheral link
  //////////////////////////////////////////////////////////////////////

  periph_link periph_link_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .s_aw_addr_i   (br_aw_addr),
    .s_aw_valid_i  (br_aw_valid),
    .s_aw_ready_o  (br_aw_ready),
    .s_w_data_i    (br_w_data),
    .s_w_strb_i    (br_w_strb),
    .s_w_valid_i   (br_w_valid),
    .s_w_ready_o   (br_w_ready),
    .s_b_resp_o    (br_b_resp),
    .s_b_valid_o   (br_b_valid),
    .s_b_ready_i   (br_b_ready),
    .s_ar_addr_i   (br_ar_addr),
    .s_ar_valid_i  (br_ar_valid),
    .s_ar_ready_o  (br_ar_ready),
    .s_r_data_o    (br_r_data),
    .s_r_resp_o    (br_r_resp),
    .s_r_valid_o   (br_r_valid),
    .s_r_ready_i   (br_r_ready),
    .rom_aw_valid_o(rom_aw_valid),
    .rom_aw_ready_i(rom_aw_ready),
    .rom_w_valid_o (rom_w_valid),
    .rom_w_ready_i (rom_w_ready),
    .rom_b_resp_i  (rom_b_resp),
    .rom_b_valid_i (rom_b_valid),
    .rom_b_ready_o (rom_b_ready),
    .rom_ar_addr_o (rom_ar_addr),
    .rom_ar_valid_o(rom_ar_valid),
    .rom_ar_ready_i(rom_ar_ready),
    .rom_r_data_i  (rom_r_data),
    .rom_r_resp_i  (rom_r_resp),
    .rom_r_valid_i (rom_r_valid),
    .rom_r_ready_o (rom_r_ready),
    .scr_aw_addr_o (scr_aw_addr),
    .scr_aw_valid_o(scr_aw_valid),
    .scr_aw_ready_i(scr_aw_ready),
    .scr_w_data_o  (scr_w_data),
    .scr_w_strb_o  (scr_w_strb),
    .scr_w_valid_o (scr_w_valid),
    .scr_w_ready_i (scr_w_ready),
    .scr_b_resp_i  (scr_b_resp),
    .scr_b_valid_i (scr_b_valid),
    .scr_b_ready_o (scr_b_ready),
    .scr_ar_addr_o (scr_ar_addr),
    .scr_ar_valid_o(scr_ar_valid),
    .scr_ar_ready_i(scr_ar_ready),
    .scr_r_data_i  (scr_r_data),
    .scr_r_resp_i  (scr_r_resp),
    .scr_r_valid_i (scr_r_valid),
    .scr_r_ready_o (scr_r_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Subordinates
  //////////////////////////////////////////////////////////////////////

  boot_rom boot_rom_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .aw_valid_i(rom_aw_valid),
    .aw_ready_o(rom_aw_ready),
    .w_valid_i (rom_w_valid),
    .w_ready_o (rom_w_ready),
    .b_resp_o  (rom_b_resp),
    .b_valid_o (rom_b_valid),
    .b_ready_i (rom_b_ready),
    .ar_addr_i (rom_ar_addr),
    .ar_valid_i(rom_ar_valid),
    .ar_ready_o(rom_ar_ready),
    .r_data_o  (rom_r_data),
    .r_resp_o  (rom_r_resp),
    .r_valid_o (rom_r_valid),
    .r_ready_i (rom_r_ready)
  );

  scratch_regs scratch_regs_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .aw_addr_i (scr_aw_addr),
    .aw_valid_i(scr_aw_valid),
    .aw_ready_o(scr_aw_ready),
    .w_data_i  (scr_w_data),
    .w_strb_i  (scr_w_strb),
    .w_valid_i (scr_w_valid),
    .w_ready_o (scr_w_ready),
    .b_resp_o  (scr_b_resp),
    .b_valid_o (scr_b_valid),
    .b_ready_i (scr_b_ready),
    .ar_addr_i (scr_ar_addr),
    .ar_valid_i(scr_ar_valid),
    .ar_ready_o(scr_ar_ready),
    .r_data_o  (scr_r_data),
    .r_resp_o  (scr_r_resp),
    .r_valid_o (scr_r_valid),
    .r_ready_i (scr_r_ready)
  );

endmodule

// File: source/dhs_pkg.sv
package dhs_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int RESP_W = 2;

  // AXI response codes
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;
  localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

  //////////////////////////////////////////////////////////////////////
  // Peripheral address map
  //////////////////////////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] ROM_BASE  = 32'h0000_0000;
  localparam int                ROM_WORDS = 64;

  localparam logic [ADDR_W-1:0] SCR_BASE  = 32'h0000_1000;
  localparam int                SCR_WORDS = 16;

  // Boot ROM fill, word index goes into the low byte
  localparam logic [DATA_W-1:0] ROM_PATTERN = 32'hB007_0000;

endpackage

// File: source/periph_link.sv
module periph_link (
  input  logic                       clk_i,
  input  logic                       arst_n_i,

  // From the bridge
  input  logic [dhs_pkg::ADDR_W-1:0] s_aw_addr_i,
  input  logic                       s_aw_valid_i,
  output logic                       s_aw_ready_o,
  input  logic [dhs_pkg::DATA_W-1:0] s_w_data_i,
  input  logic [dhs_pkg::STRB_W-1:0] s_w_strb_i,
  input  logic                       s_w_valid_i,
  output logic                       s_w_ready_o,
  output logic [dhs_pkg::RESP_W-1:0] s_b_resp_o,
  output logic                       s_b_valid_o,
  input  logic                       s_b_ready_i,
  input  logic [dhs_pkg::ADDR_W-1:0] s_ar_addr_i,
  input  logic                       s_ar_valid_i,
  output logic                       s_ar_ready_o,
  output logic [dhs_pkg::DATA_W-1:0] s_r_data_o,
  output logic [dhs_pkg::RESP_W-1:0] s_r_resp_o,
  output logic                       s_r_valid_o,
  input  logic                       s_r_ready_i,

  // Boot ROM, writes carry no payload
  output logic                       rom_aw_valid_o,
  input  logic                       rom_aw_ready_i,
  output logic                       rom_w_valid_o,
  input  logic                       rom_w_ready_i,
  input  logic [dhs_pkg::RESP_W-1:0] rom_b_resp_i,
  input  logic                       rom_b_valid_i,
  output logic                       rom_b_ready_o,
  output logic [dhs_pkg::ADDR_W-1:0] rom_ar_addr_o,
  output logic                       rom_ar_valid_o,
  input  logic                       rom_ar_ready_i,
  input  logic [dhs_pkg::DATA_W-1:0] rom_r_data_i,
  input  logic [dhs_pkg::RESP_W-1:0] rom_r_resp_i,
  input  logic                       rom_r_valid_i,
  output logic                       rom_r_ready_o,

  // Scratch bank
  output logic [dhs_pkg::ADDR_W-1:0] scr_aw_addr_o,
  output logic                       scr_aw_valid_o,
  input  logic                       scr_aw_ready_i,
  output logic [dhs_pkg::DATA_W-1:0] scr_w_data_o,
  output logic [dhs_pkg::STRB_W-1:0] scr_w_strb_o,
  output logic                       scr_w_valid_o,
  input  logic                       scr_w_ready_i,
  input  logic [dhs_pkg::RESP_W-1:0] scr_b_resp_i,
  input  logic                       scr_b_valid_i,
  output logic                       scr_b_ready_o,
  output logic [dhs_pkg::ADDR_W-1:0] scr_ar_addr_o,
  output logic                       scr_ar_valid_o,
  input  logic                       scr_ar_ready_i,
  input  logic [dhs_pkg::DATA_W-1:0] scr_r_data_i,
  input  logic [dhs_pkg::RESP_W-1:0] scr_r_resp_i,
  input  logic                       scr_r_valid_i,
  output logic                       scr_r_ready_o
);

  import dhs_pkg::*;

  typedef enum logic [1:0] {
    TGT_ERR,
    TGT_ROM,
    TGT_SCR
  } tgt_e;

  tgt_e aw_tgt;
  tgt_e ar_tgt;
  tgt_e wr_tgt_q;
  tgt_e rd_tgt_q;
  logic wr_busy_q;
  logic rd_busy_q;

  function automatic tgt_e decode(input logic [ADDR_W-1:0] addr);
    if (addr >= ROM_BASE && addr < ROM_BASE + ADDR_W'(ROM_WORDS * 4)) begin
      return TGT_ROM;
    end
    if (addr >= SCR_BASE && addr < SCR_BASE + ADDR_W'(SCR_WORDS * 4)) begin
      return TGT_SCR;
    end
    return TGT_ERR;
  endfunction

  assign aw_tgt = decode(s_aw_addr_i);
  assign ar_tgt = decode(s_ar_addr_i);

  //////////////////////////////////////////////////////////////////////
  // Request steering
  //////////////////////////////////////////////////////////////////////

  // W follows the AW decode, the bridge presents both together
  assign rom_aw_valid_o = s_aw_valid_i & ~wr_busy_q & (aw_tgt == TGT_ROM);
  assign rom_w_valid_o  = s_w_valid_i & ~wr_busy_q & (aw_tgt == TGT_ROM);
  assign scr_aw_valid_o = s_aw_valid_i & ~wr_busy_q & (aw_tgt == TGT_SCR);
  assign scr_w_valid_o  = s_w_valid_i & ~wr_busy_q & (aw_tgt == TGT_SCR);
  assign scr_aw_addr_o  = s_aw_addr_i;
  assign scr_w_data_o   = s_w_data_i;
  assign scr_w_strb_o   = s_w_strb_i;

  assign rom_ar_valid_o = s_ar_valid_i & ~rd_busy_q & (ar_tgt == TGT_ROM);
  assign scr_ar_valid_o = s_ar_valid_i & ~rd_busy_q & (ar_tgt == TGT_SCR);
  assign rom_ar_addr_o  = s_ar_addr_i;
  assign scr_ar_addr_o  = s_ar_addr_i;

  always_comb begin
    case (aw_tgt)
      TGT_ROM: begin
        s_aw_ready_o = rom_aw_ready_i & ~wr_busy_q;
        s_w_ready_o  = rom_w_ready_i & ~wr_busy_q;
      end
      TGT_SCR: begin
        s_aw_ready_o = scr_aw_ready_i & ~wr_busy_q;
        s_w_ready_o  = scr_w_ready_i & ~wr_busy_q;
      end
      default: begin
        // Error responder takes AW and W in one go
        s_aw_ready_o = s_aw_valid_i & s_w_valid_i & ~wr_busy_q;
        s_w_ready_o  = s_aw_valid_i & s_w_valid_i & ~wr_busy_q;
      end
    endcase
    case (ar_tgt)
      TGT_ROM: s_ar_ready_o = rom_ar_ready_i & ~rd_busy_q;
      TGT_SCR: s_ar_ready_o = scr_ar_ready_i & ~rd_busy_q;
      default: s_ar_ready_o = ~rd_busy_q;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Outstanding transaction tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_busy_q <= 1'b0;
      rd_busy_q <= 1'b0;
      wr_tgt_q  <= TGT_ERR;
      rd_tgt_q  <= TGT_ERR;
    end else begin
      if (s_aw_valid_i && s_aw_ready_o) begin
        wr_busy_q <= 1'b1;
        wr_tgt_q  <= aw_tgt;
      end else if (s_b_valid_o && s_b_ready_i) begin
        wr_busy_q <= 1'b0;
      end
      if (s_ar_valid_i && s_ar_ready_o) begin
        rd_busy_q <= 1'b1;
        rd_tgt_q  <= ar_tgt;
      end else if (s_r_valid_o && s_r_ready_i) begin
        rd_busy_q <= 1'b0;
      end
    end
  end

  // Response return, unmapped accesses answer DECERR the cycle after accept
  always_comb begin
    s_b_valid_o   = 1'b0;
    s_b_resp_o    = RESP_DECERR;
    rom_b_ready_o = 1'b0;
    scr_b_ready_o = 1'b0;
    if (wr_busy_q) begin
      case (wr_tgt_q)
        TGT_ROM: begin
          s_b_valid_o   = rom_b_valid_i;
          s_b_resp_o    = rom_b_resp_i;
          rom_b_ready_o = s_b_ready_i;
        end
        TGT_SCR: begin
          s_b_valid_o   = scr_b_valid_i;
          s_b_resp_o    = scr_b_resp_i;
          scr_b_ready_o = s_b_ready_i;
        end
        default: s_b_valid_o = 1'b1;
      endcase
    end
  end

  always_comb begin
    s_r_valid_o   = 1'b0;
    s_r_data_o    = '0;
    s_r_resp_o    = RESP_DECERR;
    rom_r_ready_o = 1'b0;
    scr_r_ready_o = 1'b0;
    if (rd_busy_q) begin
      case (rd_tgt_q)
        TGT_ROM: begin
          s_r_valid_o   = rom_r_valid_i;
          s_r_data_o    = rom_r_data_i;
          s_r_resp_o    = rom_r_resp_i;
          rom_r_ready_o = s_r_ready_i;
        end
        TGT_SCR: begin
          s_r_valid_o   = scr_r_valid_i;
          s_r_data_o    = scr_r_data_i;
          s_r_resp_o    = scr_r_resp_i;
          scr_r_ready_o = s_r_ready_i;
        end
        default: s_r_valid_o = 1'b1;
      endcase
    end
  end

endmodule

// File: source/scratch_regs.sv
module scratch_regs (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic [dhs_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  logic [dhs_pkg::DATA_W-1:0] w_data_i,
  input  logic [dhs_pkg::STRB_W-1:0] w_strb_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  output logic [dhs_pkg::RESP_W-1:0] b_resp_o,
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  input  logic [dhs_pkg::ADDR_W-1:0] ar_addr_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  output logic [dhs_pkg::DATA_W-1:0] r_data_o,
  output logic [dhs_pkg::RESP_W-1:0] r_resp_o,
  output logic                       r_valid_o,
  input  logic                       r_ready_i
);

  import dhs_pkg::*;

  logic [DATA_W-1:0]            mem_q [SCR_WORDS];
  logic                         wr_accept;
  logic                         rd_accept;
  logic                         b_valid_q;
  logic                         r_valid_q;
  logic [ADDR_W-1:0]            wr_off;
  logic [ADDR_W-1:0]            rd_off;
  logic [$clog2(SCR_WORDS)-1:0] wr_idx;
  logic [$clog2(SCR_WORDS)-1:0] rd_idx;
  logic [DATA_W-1:0]            r_data_q;

  assign wr_accept = aw_valid_i & w_valid_i & ~b_valid_q;
  assign rd_accept = ar_valid_i & ~r_valid_q;

  // Word index inside the bank
  assign wr_off = aw_addr_i - SCR_BASE;
  assign rd_off = ar_addr_i - SCR_BASE;
  assign wr_idx = wr_off[2 +: $clog2(SCR_WORDS)];
  assign rd_idx = rd_off[2 +: $clog2(SCR_WORDS)];

  // Register bank, only strobed bytes change
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mem_q <= '{default: '0};
    end else if (wr_accept) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (w_strb_i[b]) mem_q[wr_idx][8*b +: 8] <= w_data_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_accept) b_valid_q <= 1'b1;
      else if (b_ready_i) b_valid_q <= 1'b0;
      if (rd_accept) r_valid_q <= 1'b1;
      else if (r_ready_i) r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) r_data_q <= mem_q[rd_idx];
  end

  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;
  assign b_resp_o   = RESP_OKAY;
  assign b_valid_o  = b_valid_q;
  assign ar_ready_o = ~r_valid_q;
  assign r_data_o   = r_data_q;
  assign r_resp_o   = RESP_OKAY;
  assign r_valid_o  = r_valid_q;

endmodule

// File: src.f
source/dhs_pkg.sv
source/apb_axil_bridge.sv
source/periph_link.sv
source/boot_rom.sv
source/scratch_regs.sv
source/dhs_periph_top.sv
tests/dhs_periph_assert.sv
tests/tb_dhs_periph.sv

// File: tests/dhs_periph_assert.sv
module dhs_periph_assert (
  input logic                       clk_i,
  input logic                       arst_n_i,
  input logic                       psel_i,
  input logic                       penable_i,
  input logic                       pwrite_i,
  input logic [dhs_pkg::ADDR_W-1:0] paddr_i,
  input logic [dhs_pkg::DATA_W-1:0] pwdata_i,
  input logic [dhs_pkg::STRB_W-1:0] pstrb_i,
  input logic                       pready_i,
  input logic                       pslverr_i,
  input logic [dhs_pkg::DATA_W-1:0] prdata_i
);

  import dhs_pkg::*;

  localparam int SCR_IDX_W = $clog2(SCR_WORDS);

  logic [DATA_W-1:0]    shadow_q [SCR_WORDS];
  logic [ADDR_W-1:0]    rom_off;
  logic [ADDR_W-1:0]    scr_off;
  logic [SCR_IDX_W-1:0] scr_idx;
  logic                 rom_hit;
  logic                 scr_hit;
  logic                 done;
  logic                 rd_done;
  logic                 wr_done;
  logic [DATA_W-1:0]    rom_expect;
  logic [DATA_W-1:0]    scr_expect;
  int unsigned          err_cnt = 0;

  // Region decode, offsets wrap below the base
  assign rom_off = paddr_i - ROM_BASE;
  assign scr_off = paddr_i - SCR_BASE;
  assign rom_hit = rom_off < ADDR_W'(ROM_WORDS * 4);
  assign scr_hit = scr_off < ADDR_W'(SCR_WORDS * 4);
  assign scr_idx = scr_off[2 +: SCR_IDX_W];

  // APB transfer completes on this edge
  assign done    = psel_i & penable_i & pready_i;
  assign rd_done = done & ~pwrite_i;
  assign wr_done = done & pwrite_i;

  // ROM fill rule, word index in the low byte
  assign rom_expect = {ROM_PATTERN[DATA_W-1:8], rom_off[2 +: 8]};
  assign scr_expect = shadow_q[scr_idx];

  //////////////////////////////////////////////////////////////////////
  // Shadow of the scratch bank
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < SCR_WORDS; i++) begin
        shadow_q[i] <= '0;
      end
    end else if (wr_done && scr_hit) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (pstrb_i[b]) shadow_q[scr_idx][8*b +: 8] <= pwdata_i[8*b +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_ready_reset: assert property (@(posedge clk_i) !arst_n_i |-> !pready_i)
    else begin
      err_cnt = err_cnt + 1;
      $error("error at %0t: pready_o expected 0 observed %b", $time, $sampled(pready_i));
    end

  a_ready_phase: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pready_i |-> psel_i && penable_i)
    else begin
      err_cnt = err_cnt + 1;
      $error("error at %0t: pready_o went high outside an APB access phase", $time);
    end

  // One completion cycle per access
  a_ready_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pready_i |=> !pready_i)
    else begin
      err_cnt = err_cnt + 1;
      $error("error at %0t: pready_o expected 0 observed %b", $time, $sampled(pready_i));
    end

  a_rd_okay: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_done && (rom_hit || scr_hit) |-> !pslverr_i)
    else begin
      err_cnt = err_cnt + 1;
      $error("error at %0t: pslverr_o expected 0 observed %b", $time, $sampled(pslverr_i));
    end

  a_rom_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_done && rom_hit |-> prdata_i == rom_expect)
    else begin
      err_cnt = err_cnt + 1;
      $error("error at %0t: prdata_o expected %h observed %h", $time,
             $sampled(rom_expect), $sampled(prdata_i));
    end

  a_scr_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_done && scr_hit |-> prdata_i == scr_expect)
    else begin
      err_cnt = err_cnt + 1;
      $error("error at %0t: prdata_o expected %h observed %h", $time,
             $sampled(scr_expect), $sampled(prdata_i));
    end

  // ROM rejects writes, scratch bank takes them
  a_wr_resp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_done && (rom_hit || scr_hit) |-> pslverr_i == rom_hit)
    else begin
      err_cnt = err_cnt + 1;
      $error("error at %0t: pslverr_o expected %b observed %b", $time,
             $sampled(rom_hit), $sampled(pslverr_i));
    end

  a_unmapped_err: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done && !rom_hit && !scr_hit |-> pslverr_i)
    else begin
      err_cnt = err_cnt + 1;
      $error("error at %0t: pslverr_o expected 1 observed %b", $time, $sampled(pslverr_i));
    end

endmodule

bind dhs_periph_top dhs_periph_assert periph_check_i (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .psel_i   (psel_i),
  .penable_i(penable_i),
  .pwrite_i (pwrite_i),
  .paddr_i  (paddr_i),
  .pwdata_i (pwdata_i),
  .pstrb_i  (pstrb_i),
  .pready_i (pready_o),
  .pslverr_i(pslverr_o),
  .prdata_i (prdata_o)
);

// File: tests/tb_dhs_periph.sv
module tb_dhs_periph;

  import dhs_pkg::*;

  localparam int          CLK_PERIOD     = 40;
  localparam int          RESET_CYC      = 4;
  localparam int          NUM_TESTS      = 400;
  localparam int          DIRECTED_TESTS = 4;
  localparam int          MAX_ACC_CYC    = 16;
  localparam int          WATCHDOG_TIME  =
    (RESET_CYC + (NUM_TESTS + DIRECTED_TESTS) * MAX_ACC_CYC) * CLK_PERIOD;
  localparam int unsigned SEED           = 98347;

  logic              clk_i;
  logic              arst_n_i;
  logic              psel_i;
  logic              penable_i;
  logic              pwrite_i;
  logic [ADDR_W-1:0] paddr_i;
  logic [DATA_W-1:0] pwdata_i;
  logic [STRB_W-1:0] pstrb_i;
  logic              pready_o;
  logic              pslverr_o;
  logic [DATA_W-1:0] prdata_o;

  dhs_periph_top dhs_periph_top_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .paddr_i  (paddr_i),
    .pwdata_i (pwdata_i),
    .pstrb_i  (pstrb_i),
    .pready_o (pready_o),
    .pslverr_o(pslverr_o),
    .prdata_o (prdata_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure(input string why);
    $display("Something failed");
    $fatal(1, "%s", why);
  endtask

  function automatic logic [ADDR_W-1:0] rom_addr(input int idx);
    return ROM_BASE + ADDR_W'(4 * idx);
  endfunction

  function automatic logic [ADDR_W-1:0] scr_addr(input int idx);
    return SCR_BASE + ADDR_W'(4 * idx);
  endfunction

  // Just past either region, or far above both
  function automatic logic [ADDR_W-1:0] pick_unmapped();
    logic [ADDR_W-1:0] addr;
    case ($urandom_range(0, 2))
      0: addr = rom_addr(ROM_WORDS + int'($urandom_range(0, 15)));
      1: addr = scr_addr(SCR_WORDS + int'($urandom_range(0, 15)));
      default: addr = $urandom() | 32'h8000_0000;
    endcase
    return {addr[ADDR_W-1:2], 2'b00};
  endfunction

  // Starts and ends on a falling edge
  task automatic apb_access(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = data;
    pstrb_i   = strb;
    @(negedge clk_i);
    penable_i = 1'b1;
    @(negedge clk_i);
    while (!pready_o) @(negedge clk_i);
    // Completion edge is the next rising edge
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic random_access();
    case ($urandom_range(0, 4))
      0: begin
        apb_access(1'b1, scr_addr(int'($urandom_range(0, SCR_WORDS - 1))), $urandom(),
                   STRB_W'($urandom_range(0, 15)));
      end
      1: apb_access(1'b0, scr_addr(int'($urandom_range(0, SCR_WORDS - 1))), '0, '0);
      2: apb_access(1'b0, rom_addr(int'($urandom_range(0, ROM_WORDS - 1))), '0, '0);
      3: begin
        apb_access(1'b1, rom_addr(int'($urandom_range(0, ROM_WORDS - 1))), $urandom(),
                   STRB_W'($urandom_range(0, 15)));
      end
      default: begin
        apb_access($urandom_range(0, 1) == 1, pick_unmapped(), $urandom(), '1);
      end
    endcase
    repeat ($urandom_range(0, 2)) @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus, watcher and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    clk_i     = 1'b0;
    arst_n_i  = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    pstrb_i   = '0;
    repeat (RESET_CYC) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);

    // ROM word must survive a write
    apb_access(1'b1, rom_addr(5), 32'hDEAD_BEEF, '1);
    apb_access(1'b0, rom_addr(5), '0, '0);
    apb_access(1'b1, scr_addr(3), 32'h1234_5678, 4'b0101);
    apb_access(1'b0, scr_addr(3), '0, '0);

    repeat (NUM_TESTS) random_access();
    repeat (2) @(negedge clk_i);

    if (dhs_periph_top_i.periph_check_i.err_cnt != 0) begin
      stop_on_failure("assertion errors were reported during the run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

  always @(negedge clk_i) begin
    if (dhs_periph_top_i.periph_check_i.err_cnt != 0) begin
      stop_on_failure("a bound assertion reported an error");
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    stop_on_failure("timeout, the APB accesses did not finish in time");
  end

endmodule
